//--- decode_const_consts.svh
// Width and encoding constants for the constant-decoding slice of the decode stage
`ifndef DECODE_CONST_CONSTS_SVH
`define DECODE_CONST_CONSTS_SVH

// ====================
// Line geometry
// ====================

// A fetched cache line is 512 bits wide
`define LINE_W 512

// Every instruction and every constant slot is one 32-bit word
`define INSN_W 32

// Sixteen words make up one line
`define WORDS_PER_LINE 16

// Four bits address a word inside the line
`define POS_W 4

// ====================
// Instruction fields
// ====================

// Immediates leave the decoder as 64-bit values
`define IMM_W 64

// The inline immediate field sits in bits 30:17
`define INLINE_W 14

// The opcode occupies the low seven bits
`define OPCODE_W 7

// Constant size code carried in the extended form
`define CSIZE_W 2

// Form codes held in bits 31:29 of the instruction
`define FORM_REG 3'b100
`define FORM_EXT 3'b111

`endif

//--- decode_const_pkg.sv
// Shared types for the constant decoder: widths, opcodes and stage-to-stage records
`include "decode_const_consts.svh"

package decode_const_pkg;

	// ====================
	// Vector types
	// ====================

	// Whole cache line with word 0 in bits 31:0
	typedef logic [`LINE_W-1:0] cline_t;

	// One raw instruction word
	typedef logic [`INSN_W-1:0] insn_t;

	// Index of a word within the line
	typedef logic [`POS_W-1:0] word_idx_t;

	// Size code of an extended constant (16, 32, 64 bits or none)
	typedef logic [`CSIZE_W-1:0] csize_t;

	// Fully extended immediate value
	typedef logic [`IMM_W-1:0] imm_t;

	// One bit per line word
	typedef logic [`WORDS_PER_LINE-1:0] word_mask_t;

	// Opcodes that carry immediates in this slice
	// Byte, wyde and tetra variants are folded into LOAD and STORE
	typedef enum logic [`OPCODE_W-1:0] {
		OP_ADD    = 7'h04,
		OP_CMP    = 7'h05,
		OP_CMPU   = 7'h06,
		OP_AND    = 7'h08,
		OP_OR     = 7'h09,
		OP_XOR    = 7'h0A,
		OP_SHIFT  = 7'h0C,
		OP_BCC    = 7'h20,
		OP_B      = 7'h21,
		OP_LOAD   = 7'h30,
		OP_STORE  = 7'h38,
		OP_STOREI = 7'h3C
	} opcode_e;

	// ====================
	// Stage records
	// ====================

	// Request entering the stage, 516 bits
	typedef struct packed {
		cline_t    line;
		word_idx_t idx;
	} line_req_t;

	// Registered line plus the instruction picked out of it, 544 bits
	typedef struct packed {
		cline_t line;
		insn_t  insn;
	} insn_pkt_t;

	// Combinational decode result
	typedef struct packed {
		imm_t      immb;
		imm_t      immc;
		logic      has_immb;
		logic      has_immc;
		logic      use_c1;
		logic      use_c2;
		word_idx_t pos1;
		word_idx_t pos2;
		csize_t    size1;
		csize_t    size2;
	} const_result_t;

	// Registered result with the mask of words taken up by constants
	typedef struct packed {
		imm_t       immb;
		imm_t       immc;
		logic       has_immb;
		logic       has_immc;
		logic       use_c1;
		logic       use_c2;
		word_idx_t  pos1;
		word_idx_t  pos2;
		csize_t     size1;
		csize_t     size2;
		word_mask_t word_mask;
	} const_out_t;

endpackage

//--- insn_line_align.sv
// Input stage that captures the cache line and pulls out the addressed instruction word
`include "decode_const_consts.svh"

module insn_line_align
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        line_strobe,
	input  decode_const_pkg::line_req_t line_req,
	output logic                        insn_strobe,
	output decode_const_pkg::insn_pkt_t insn_pkt
);

	// Word selected by the request index
	decode_const_pkg::insn_t sel_insn;

	// ====================
	// Word select
	// ====================

	// Each word is 32 bits so the index scales straight into a bit offset
	// Index 15 lands on bits 511:480 which is always in range
	always_comb
	begin
		sel_insn = line_req.line[line_req.idx*`INSN_W +: `INSN_W];
	end

	// ====================
	// Registers
	// ====================

	// The strobe is a single-cycle pulse delayed by one clock
	always_ff @(posedge clk)
	begin
		if (reset)
			insn_strobe <= 1'b0;
		else
			insn_strobe <= line_strobe;
	end

	// Line and instruction only load when a request arrives
	// Between strobes the last item stays put
	always_ff @(posedge clk)
	begin
		if (line_strobe)
		begin
			insn_pkt.line <= line_req.line;
			insn_pkt.insn <= sel_insn;
		end
	end

endmodule

//--- const_field_extract.sv
// Extended constant reader that slices a 16, 32 or 64 bit value from a line word position
`include "decode_const_consts.svh"

module const_field_extract
(
	input  decode_const_pkg::cline_t    line,
	input  decode_const_pkg::word_idx_t pos,
	input  decode_const_pkg::csize_t    size,
	output decode_const_pkg::imm_t      cnst
);

	// One bit wider than pos so that word 15 plus one does not wrap to word 0
	logic [`POS_W:0] hi_idx;

	// Word at pos and the word after it
	logic [`INSN_W-1:0] word_lo;
	logic [`INSN_W-1:0] word_hi;

	// Fetch the low word and, if it exists, the next one
	always_comb
	begin
		hi_idx = {1'b0, pos} + 1'b1;
		word_lo = line[pos*`INSN_W +: `INSN_W];
		// A 64-bit constant in the last word has nothing above it
		if (hi_idx < `WORDS_PER_LINE)
			word_hi = line[hi_idx[`POS_W-1:0]*`INSN_W +: `INSN_W];
		else
			word_hi = '0;
	end

	// Size code picks the width and sign-extends to 64 bits
	always_comb
	begin
		case (size)
		2'b00:
			// Low half of the word only
			cnst = {{(`IMM_W-16){word_lo[15]}}, word_lo[15:0]};
		2'b01:
			cnst = {{(`IMM_W-`INSN_W){word_lo[`INSN_W-1]}}, word_lo};
		2'b10:
			// Low word at pos, high word at pos+1
			cnst = {word_hi, word_lo};
		default:
			cnst = '0;	// size 11 carries no constant
		endcase
	end

endmodule

//--- decode_const.sv
// Immediate decoder that builds immb/immc from inline fields or extended line constants
`include "decode_const_consts.svh"

module decode_const
(
	input  decode_const_pkg::insn_pkt_t     pkt,
	output decode_const_pkg::const_result_t result
);

	// Opcode seen through the enum
	decode_const_pkg::opcode_e opcode;

	// Form bits and the two forms that change the decode
	logic [2:0] form;
	logic       reg_form;
	logic       ext_form;

	// Position and size fields of the extended form
	decode_const_pkg::word_idx_t pos1;
	decode_const_pkg::word_idx_t pos2;
	decode_const_pkg::csize_t    size1;
	decode_const_pkg::csize_t    size2;

	// Extended constants read from the line
	decode_const_pkg::imm_t c1;
	decode_const_pkg::imm_t c2;

	// Candidate inline immediates
	decode_const_pkg::imm_t inline_sext;
	decode_const_pkg::imm_t inline_zext;
	decode_const_pkg::imm_t inline_oext;
	decode_const_pkg::imm_t shift_amt;
	decode_const_pkg::imm_t bcc_disp;
	decode_const_pkg::imm_t b_disp;

	// ====================
	// Field split
	// ====================

	assign opcode   = decode_const_pkg::opcode_e'(pkt.insn[`OPCODE_W-1:0]);
	assign form     = pkt.insn[31:29];
	assign reg_form = (form == `FORM_REG);
	assign ext_form = (form == `FORM_EXT);

	// These fields overlap the inline immediate and only mean something in extended form
	assign pos1  = pkt.insn[20:17];
	assign pos2  = pkt.insn[24:21];
	assign size1 = pkt.insn[26:25];
	assign size2 = pkt.insn[28:27];

	// 14-bit field with its three extension flavours
	assign inline_sext = {{(`IMM_W-`INLINE_W){pkt.insn[30]}}, pkt.insn[30:17]};
	assign inline_zext = {{(`IMM_W-`INLINE_W){1'b0}}, pkt.insn[30:17]};
	assign inline_oext = {{(`IMM_W-`INLINE_W){1'b1}}, pkt.insn[30:17]};

	// Shift amount is six bits and never negative
	assign shift_amt = {{(`IMM_W-6){1'b0}}, pkt.insn[22:17]};

	// Branch displacements are word aligned so two zero bits go underneath
	assign bcc_disp = {{(`IMM_W-13){pkt.insn[30]}}, pkt.insn[30:29], pkt.insn[16:9],
		pkt.insn[0], 2'b00};
	assign b_disp = {{(`IMM_W-25){pkt.insn[30]}}, pkt.insn[30:9], pkt.insn[0], 2'b00};

	// ====================
	// Constant readers
	// ====================

	// First constant feeds immb
	const_field_extract u_c1
	(
		.line (pkt.line),
		.pos  (pos1),
		.size (size1),
		.cnst (c1)
	);

	// Second constant only feeds the store data of STOREI
	const_field_extract u_c2
	(
		.line (pkt.line),
		.pos  (pos2),
		.size (size2),
		.cnst (c2)
	);

	// ====================
	// Opcode rules
	// ====================

	always_comb
	begin
		// Unknown opcodes fall through with everything zero
		result = '0;
		case (opcode)
		decode_const_pkg::OP_ADD, decode_const_pkg::OP_CMP,
		decode_const_pkg::OP_LOAD, decode_const_pkg::OP_STORE:
			begin
				result.immb     = ext_form ? c1 : inline_sext;
				result.use_c1   = ext_form;
				result.has_immb = !reg_form;
			end
		decode_const_pkg::OP_CMPU, decode_const_pkg::OP_OR, decode_const_pkg::OP_XOR:
			begin
				result.immb     = ext_form ? c1 : inline_zext;
				result.use_c1   = ext_form;
				result.has_immb = !reg_form;
			end
		decode_const_pkg::OP_AND:
			begin
				// Ones above the field keep the upper bits of the operand intact
				result.immb     = ext_form ? c1 : inline_oext;
				result.use_c1   = ext_form;
				result.has_immb = !reg_form;
			end
		decode_const_pkg::OP_SHIFT:
			begin
				// Bit 31 clear selects the immediate shift amount
				result.immb     = shift_amt;
				result.has_immb = !pkt.insn[31];
			end
		decode_const_pkg::OP_BCC:
			begin
				result.immb     = ext_form ? c1 : bcc_disp;
				result.use_c1   = ext_form;
				result.has_immb = !reg_form;
			end
		decode_const_pkg::OP_B:
			begin
				// An unconditional branch always has a target
				result.immb     = ext_form ? c1 : b_disp;
				result.use_c1   = ext_form;
				result.has_immb = 1'b1;
			end
		decode_const_pkg::OP_STOREI:
			begin
				// Address offset as for STORE, store data comes from the line
				result.immb     = ext_form ? c1 : inline_sext;
				result.use_c1   = ext_form;
				result.has_immb = !reg_form;
				result.immc     = c2;
				result.has_immc = 1'b1;
				result.use_c2   = 1'b1;
			end
		default:
			begin
				result = '0;
			end
		endcase

		// Positions and sizes are reported only for constants actually taken
		if (result.use_c1)
		begin
			result.pos1  = pos1;
			result.size1 = size1;
		end
		if (result.use_c2)
		begin
			result.pos2  = pos2;
			result.size2 = size2;
		end
	end

endmodule

//--- imm_result_stage.sv
// Output stage that registers the decode result and marks the line words used by constants
`include "decode_const_consts.svh"

module imm_result_stage
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            insn_strobe,
	input  decode_const_pkg::const_result_t result,
	output logic                            out_strobe,
	output decode_const_pkg::const_out_t    const_out
);

	// Record assembled ahead of the output register
	decode_const_pkg::const_out_t out_next;

	// Words covered by one constant of the given position and size
	function automatic decode_const_pkg::word_mask_t occ_mask
	(
		input decode_const_pkg::word_idx_t pos,
		input decode_const_pkg::csize_t    size
	);
		logic [`POS_W:0]             nxt;
		decode_const_pkg::word_mask_t m;

		nxt = {1'b0, pos} + 1'b1;
		m = '0;
		case (size)
		2'b00, 2'b01:
			m[pos] = 1'b1;
		2'b10:
			begin
				m[pos] = 1'b1;
				// The high word of a 64-bit constant at word 15 lies off the line
				if (nxt < `WORDS_PER_LINE)
					m[nxt[`POS_W-1:0]] = 1'b1;
			end
		default:
			m = '0;
		endcase
		return m;
	endfunction

	// ====================
	// Mask build
	// ====================

	// Union of the words used by both constants
	always_comb
	begin
		out_next.immb      = result.immb;
		out_next.immc      = result.immc;
		out_next.has_immb  = result.has_immb;
		out_next.has_immc  = result.has_immc;
		out_next.use_c1    = result.use_c1;
		out_next.use_c2    = result.use_c2;
		out_next.pos1      = result.pos1;
		out_next.pos2      = result.pos2;
		out_next.size1     = result.size1;
		out_next.size2     = result.size2;
		out_next.word_mask = '0;
		if (result.use_c1)
			out_next.word_mask = out_next.word_mask | occ_mask(result.pos1, result.size1);
		if (result.use_c2)
			out_next.word_mask = out_next.word_mask | occ_mask(result.pos2, result.size2);
	end

	// ====================
	// Registers
	// ====================

	// Second pipeline step of the strobe
	always_ff @(posedge clk)
	begin
		if (reset)
			out_strobe <= 1'b0;
		else
			out_strobe <= insn_strobe;
	end

	// Result is captured only alongside a strobe
	always_ff @(posedge clk)
	begin
		if (insn_strobe)
			const_out <= out_next;
	end

endmodule

//--- decode_const_top.sv
// Top level of the constant decoder joining the align, decode and result stages

module decode_const_top
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         line_strobe,
	input  decode_const_pkg::line_req_t  line_req,
	output logic                         out_strobe,
	output decode_const_pkg::const_out_t const_out
);

	// Aligned line and instruction, one cycle after the request
	logic                        insn_strobe;
	decode_const_pkg::insn_pkt_t insn_pkt;

	// Combinational decode of the aligned instruction
	decode_const_pkg::const_result_t result;

	// First register stage
	insn_line_align u_align
	(
		.clk         (clk),
		.reset       (reset),
		.line_strobe (line_strobe),
		.line_req    (line_req),
		.insn_strobe (insn_strobe),
		.insn_pkt    (insn_pkt)
	);

	// Decode sits between the two registers and adds no latency
	decode_const u_decode
	(
		.pkt    (insn_pkt),
		.result (result)
	);

	// Second register stage where out_strobe follows line_strobe by two clocks
	imm_result_stage u_result
	(
		.clk         (clk),
		.reset       (reset),
		.insn_strobe (insn_strobe),
		.result      (result),
		.out_strobe  (out_strobe),
		.const_out   (const_out)
	);

endmodule

//--- decode_const_assert.sv
// Bound checker for strobe latency, quiet reset exit and constant flag consistency

module decode_const_assert
(
	input logic                         clk,
	input logic                         reset,
	input logic                         line_strobe,
	input logic                         out_strobe,
	input decode_const_pkg::const_out_t const_out
);

	// Running count of failed assertions
	int fail_count = 0;

	// ====================
	// Strobe timing
	// ====================

	// Each accepted line leaves the pipeline exactly two clocks later
	latency_fwd: assert property (@(posedge clk) disable iff (reset)
		line_strobe |-> ##2 out_strobe)
	else
	begin
		fail_count++;
		$error("line_strobe was not followed by out_strobe two cycles later");
	end

	// No output appears without a matching request
	latency_back: assert property (@(posedge clk) disable iff (reset)
		out_strobe |-> $past(line_strobe, 2))
	else
	begin
		fail_count++;
		$error("out_strobe without line_strobe two cycles earlier");
	end

	// The output strobe stays low for the two clocks after reset drops
	reset_quiet: assert property (@(posedge clk)
		$fell(reset) |-> !out_strobe ##1 !out_strobe)
	else
	begin
		fail_count++;
		$error("out_strobe rose in the cycles right after reset");
	end

	// ====================
	// Flag consistency
	// ====================

	// Store data only ever comes from the second constant
	// Its word also has to show up in the occupied mask unless size 11 leaves it empty
	immc_source: assert property (@(posedge clk) disable iff (reset)
		(out_strobe && const_out.has_immc) |-> (const_out.use_c2
			&& (const_out.size2 == 2'b11 || const_out.word_mask[const_out.pos2])))
	else
	begin
		fail_count++;
		$error("has_immc set without use_c2 or without its word in word_mask");
	end

endmodule

//--- decode_const_tb.sv
// Testbench for the constant decoder that replays file vectors and checks every output
`include "decode_const_consts.svh"

module decode_const_tb;

	// Ten entries per vector
	// An unused record keeps a fill far above any word index in its index entry
	localparam int REC_LEN = 10;
	localparam int MAX_VEC = 64;

	logic                         clk;
	logic                         reset;
	logic                         line_strobe;
	decode_const_pkg::line_req_t  line_req;
	logic                         out_strobe;
	decode_const_pkg::const_out_t const_out;

	logic [63:0] vec_mem [0:MAX_VEC*REC_LEN-1];
	logic        loaded = 1'b0;
	logic [31:0] rng_state;
	int          num_vec;
	int          cycle_count = 0;
	int          value_errors;
	int          other_errors;

	// Vectors in flight and the clock count at which each was driven
	int exp_q[$];
	int issue_q[$];

	decode_const_top u_decode_const_top
	(
		.clk         (clk),
		.reset       (reset),
		.line_strobe (line_strobe),
		.line_req    (line_req),
		.out_strobe  (out_strobe),
		.const_out   (const_out)
	);

	bind decode_const_top decode_const_assert u_assert
	(
		.clk         (clk),
		.reset       (reset),
		.line_strobe (line_strobe),
		.out_strobe  (out_strobe),
		.const_out   (const_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;

		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// ====================
	// Line assembly
	// ====================

	// Random words everywhere, then the listed constants, then the instruction on top
	function automatic decode_const_pkg::cline_t build_line(input int v);
		decode_const_pkg::cline_t line;
		logic [63:0]              pos;
		logic [63:0]              data;
		int                       base;

		base = v * REC_LEN;
		for (int w = 0; w < `WORDS_PER_LINE; w++)
		begin
			rng_state = xorshift32(rng_state);
			line[w*`INSN_W +: `INSN_W] = rng_state;
		end
		for (int k = 0; k < 2; k++)
		begin
			pos  = vec_mem[base + 2 + 2*k];
			data = vec_mem[base + 3 + 2*k];
			if (pos < `WORDS_PER_LINE)
				line[pos*`INSN_W +: `INSN_W] = data[31:0];
			// High word goes to the next slot unless it would fall off the line
			if (pos < `WORDS_PER_LINE - 1)
				line[(pos+1)*`INSN_W +: `INSN_W] = data[63:32];
		end
		line[vec_mem[base][`POS_W-1:0]*`INSN_W +: `INSN_W] = vec_mem[base + 1][31:0];
		return line;
	endfunction

	task automatic drive_vector(input int v);
		line_req.line = build_line(v);
		line_req.idx  = vec_mem[v*REC_LEN][`POS_W-1:0];
		line_strobe   = 1'b1;
		exp_q.push_back(v);
		issue_q.push_back(cycle_count);
	endtask

	// ====================
	// Compare tasks
	// ====================

	task automatic check_imm(input string name, input decode_const_pkg::imm_t got,
		input decode_const_pkg::imm_t exp, input int v);
		if (got !== exp)
		begin
			value_errors++;
			$display("Error: %s = %h, expected %h (vector %0d)", name, got, exp, v);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp, input int v);
		if (got !== exp)
		begin
			value_errors++;
			$display("Error: %s = %h, expected %h (vector %0d)", name, got, exp, v);
		end
	endtask

	task automatic check_mask(input string name, input decode_const_pkg::word_mask_t got,
		input decode_const_pkg::word_mask_t exp, input int v);
		if (got !== exp)
		begin
			value_errors++;
			$display("Error: %s = %h, expected %h (vector %0d)", name, got, exp, v);
		end
	endtask

	task automatic check_pos(input string name, input decode_const_pkg::word_idx_t got,
		input decode_const_pkg::word_idx_t exp, input int v);
		if (got !== exp)
		begin
			value_errors++;
			$display("Error: %s = %h, expected %h (vector %0d)", name, got, exp, v);
		end
	endtask

	task automatic check_size(input string name, input decode_const_pkg::csize_t got,
		input decode_const_pkg::csize_t exp, input int v);
		if (got !== exp)
		begin
			value_errors++;
			$display("Error: %s = %h, expected %h (vector %0d)", name, got, exp, v);
		end
	endtask

	// Outputs are sampled on the falling edge, half a period after they settle
	always @(negedge clk)
	begin : watch_output
		int                      v;
		int                      issued;
		int                      base;
		decode_const_pkg::insn_t insn;

		if (!reset && out_strobe)
		begin
			if (exp_q.size() == 0)
			begin
				other_errors++;
				$display("out_strobe rose at cycle %0d with nothing outstanding", cycle_count);
			end
			else
			begin
				v      = exp_q.pop_front();
				issued = issue_q.pop_front();
				base   = v * REC_LEN;
				insn   = vec_mem[base + 1][31:0];
				if (cycle_count - issued != 2)
				begin
					other_errors++;
					$display("Vector %0d came out after %0d cycles, not 2", v, cycle_count - issued);
				end
				check_imm("immb", const_out.immb, vec_mem[base + 6], v);
				check_imm("immc", const_out.immc, vec_mem[base + 7], v);
				check_flag("has_immb", const_out.has_immb, vec_mem[base + 8][3], v);
				check_flag("has_immc", const_out.has_immc, vec_mem[base + 8][2], v);
				check_flag("use_c1", const_out.use_c1, vec_mem[base + 8][1], v);
				check_flag("use_c2", const_out.use_c2, vec_mem[base + 8][0], v);
				check_mask("word_mask", const_out.word_mask, vec_mem[base + 9][15:0], v);
				// Position and size fields of the extended form matter only for a constant in use
				if (vec_mem[base + 8][1])
				begin
					check_pos("pos1", const_out.pos1, insn[20:17], v);
					check_size("size1", const_out.size1, insn[26:25], v);
				end
				if (vec_mem[base + 8][0])
				begin
					check_pos("pos2", const_out.pos2, insn[24:21], v);
					check_size("size2", const_out.size2, insn[28:27], v);
				end
			end
		end
	end

	// ====================
	// Main sequence
	// ====================

	initial
	begin : main
		int wait_cycles;
		int total;

		reset        = 1'b1;
		line_strobe  = 1'b0;
		line_req     = '0;
		num_vec      = 0;
		value_errors = 0;
		other_errors = 0;
		rng_state    = 32'h4f2;
		for (int i = 0; i < MAX_VEC*REC_LEN; i++)
			vec_mem[i] = {32'hffff_ffff, 32'(i)};
		$readmemh("decode_const_stimulus.txt", vec_mem);
		while (num_vec < MAX_VEC && vec_mem[num_vec*REC_LEN] < `WORDS_PER_LINE)
			num_vec++;
		loaded = 1'b1;
		if (num_vec == 0)
		begin
			other_errors++;
			$display("No vectors could be read from the stimulus file");
		end
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		// Mostly back to back, with an idle cycle after every fifth line
		for (int v = 0; v < num_vec; v++)
		begin
			@(posedge clk);
			#1;
			drive_vector(v);
			if (v % 5 == 4)
			begin
				@(posedge clk);
				#1;
				line_strobe = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		line_strobe = 1'b0;
		wait_cycles = 0;
		while (exp_q.size() != 0 && wait_cycles < 8)
		begin
			@(posedge clk);
			wait_cycles++;
		end
		if (exp_q.size() != 0)
		begin
			other_errors += exp_q.size();
			$display("%0d expected outputs never showed up on out_strobe", exp_q.size());
		end
		repeat (2) @(posedge clk);
		total = value_errors + other_errors + u_decode_const_top.u_assert.fail_count;
		$display("Run complete: %0d value errors, %0d other errors, %0d assertion failures",
			value_errors, other_errors, u_decode_const_top.u_assert.fail_count);
		if (total == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Budget of one clock per vector plus twenty for reset, idle gaps and draining
	initial
	begin : watchdog
		wait (loaded === 1'b1);
		#((num_vec + 20) * 4);
		$display("Timeout after %0d time units with outputs still pending", (num_vec + 20) * 4);
		$display("Test failed");
		$finish;
	end

endmodule

//--- decode_const_stimulus.txt
// idx insn | c1 word pos, 64-bit c1 data | c2 word pos, c2 data (pos ff = none placed)
// expected: immb immc flags(has_immb has_immc use_c1 use_c2) word_mask
3 7fe00004 ff 0000000000000000 ff 0000000000000000 fffffffffffffff0 0000000000000000 8 0000
0 7fe00006 ff 0000000000000000 ff 0000000000000000 0000000000003ff0 0000000000000000 8 0000
7 02460008 ff 0000000000000000 ff 0000000000000000 ffffffffffffc123 0000000000000000 8 0000
f 15780004 ff 0000000000000000 ff 0000000000000000 0000000000000abc 0000000000000000 8 0000
2 800a0004 ff 0000000000000000 ff 0000000000000000 0000000000000005 0000000000000000 0 0000
9 80000030 ff 0000000000000000 ff 0000000000000000 0000000000000000 0000000000000000 0 0000
4 005a000c ff 0000000000000000 ff 0000000000000000 000000000000002d 0000000000000000 8 0000
d 805a000c ff 0000000000000000 ff 0000000000000000 000000000000002d 0000000000000000 0 0000
0 e00a0004 05 0000000012348001 ff 0000000000000000 ffffffffffff8001 0000000000000000 a 0020
4 e2020005 01 0000000087654321 ff 0000000000000000 ffffffff87654321 0000000000000000 a 0002
c e4140030 0a 0123456789abcdef ff 0000000000000000 0123456789abcdef 0000000000000000 a 0c00
1 e41e0038 0f deadbeefcafef00d ff 0000000000000000 00000000cafef00d 0000000000000000 a 8000
8 e60c0009 ff 0000000000000000 ff 0000000000000000 0000000000000000 0000000000000000 a 0000
0 f3a6003c 03 000000007fff0001 0d fedcba9876543210 000000007fff0001 fedcba9876543210 f 6008
2 08e0003c 07 0000000000c0ffee ff 0000000000000000 0000000000000470 0000000000c0ffee d 0080
5 4000b420 ff 0000000000000000 ff 0000000000000000 fffffffffffff2d0 0000000000000000 8 0000
b 5579bc21 ff 0000000000000000 ff 0000000000000000 ffffffffff55e6f4 0000000000000000 8 0000
6 80000021 ff 0000000000000000 ff 0000000000000000 0000000000000004 0000000000000000 8 0000
e e4140013 0a 1111111122222222 ff 0000000000000000 0000000000000000 0000000000000000 0 0000
a 7ffe0000 ff 0000000000000000 ff 0000000000000000 0000000000000000 0000000000000000 0 0000

//--- flist.f
+incdir+.
decode_const_pkg.sv
insn_line_align.sv
const_field_extract.sv
decode_const.sv
imm_result_stage.sv
decode_const_top.sv
decode_const_assert.sv
decode_const_tb.sv
